// ==== src/rvPkg.sv ====
package rvPkg;

	localparam int XLEN = 32;
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_OPIMM  = 7'b0010011,
		OP_OP     = 7'b0110011,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		PASSB
	} aluOp_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wbSrc_e;

	typedef enum logic [1:0] {
		MEM_WORD,
		MEM_BYTE,
		MEM_BYTEU
	} memSize_e;

	// Instruction formats with the MSB first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e opcode;
	} rType_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e opcode;
	} iType_t;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		opcode_e opcode;
	} sType_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic imm11;
		opcode_e opcode;
	} bType_t;

	typedef struct packed {
		logic [19:0] imm31to12;
		logic [4:0] rd;
		opcode_e opcode;
	} uType_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		opcode_e opcode;
	} jType_t;

	typedef union packed {
		rType_t r;
		iType_t i;
		sType_t s;
		bType_t b;
		uType_t u;
		jType_t j;
	} instrWord_u;

	typedef struct packed {
		aluOp_e aluOp;
		logic aluSrcA;
		logic aluSrcB;
		logic isBranch;
		logic [2:0] branchFunct;
		logic isJump;
		logic isJalr;
		logic memRead;
		logic memWrite;
		memSize_e memSize;
		wbSrc_e wbSrc;
		logic regWe;
		logic halt;
	} ctrlBundle_t;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] rs1Data;
		logic [XLEN-1:0] rs2Data;
		logic [4:0] rd;
		ctrlBundle_t ctrl;
	} idExBundle_t;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] aluResult;
		logic [XLEN-1:0] storeData;
		logic [XLEN-1:0] pcPlus4;
		logic [4:0] rd;
		ctrlBundle_t ctrl;
	} exMemBundle_t;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] wbData;
		logic [4:0] rd;
		logic regWe;
		logic halt;
	} memWbBundle_t;

endpackage

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder import rvPkg::*; (
	input instrWord_u instr,
	output ctrlBundle_t ctrl,
	output logic [XLEN-1:0] imm,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic legal
);

	logic [XLEN-1:0] immI;
	logic [XLEN-1:0] immS;
	logic [XLEN-1:0] immB;
	logic [XLEN-1:0] immU;
	logic [XLEN-1:0] immJ;
	logic [6:0] funct7;
	logic [2:0] funct3;

	function automatic aluOp_e aluFromFunct(input logic [2:0] f3, input logic f7b5,
			input logic isReg);
		case (f3)
			3'b000: return (isReg && f7b5) ? SUB : ADD;
			3'b001: return SLL;
			3'b010: return SLT;
			3'b011: return SLTU;
			3'b100: return XOR;
			3'b101: return f7b5 ? SRA : SRL;
			3'b110: return OR;
			default: return AND;
		endcase
	endfunction

	// Register fields sit at the same place in every format
	assign rs1 = instr.r.rs1;
	assign rs2 = instr.r.rs2;
	assign rd = instr.r.rd;
	assign funct7 = instr.r.funct7;
	assign funct3 = instr.r.funct3;

	assign immI = {{20{instr.i.imm[11]}}, instr.i.imm};
	assign immS = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
	assign immB = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11, instr.b.imm10to5,
		instr.b.imm4to1, 1'b0};
	assign immU = {instr.u.imm31to12, 12'b0};
	assign immJ = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12, instr.j.imm11,
		instr.j.imm10to1, 1'b0};

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = ADD;
		ctrl.memSize = MEM_WORD;
		ctrl.wbSrc = WB_ALU;
		imm = '0;
		legal = 1'b1;
		case (instr.r.opcode)
			OP_LUI: begin
				ctrl.aluOp = PASSB;
				ctrl.aluSrcB = 1'b1;
				ctrl.regWe = 1'b1;
				imm = immU;
			end
			OP_AUIPC: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 1'b1;
				ctrl.regWe = 1'b1;
				imm = immU;
			end
			OP_JAL: begin
				ctrl.isJump = 1'b1;
				ctrl.wbSrc = WB_PC4;
				ctrl.regWe = 1'b1;
				imm = immJ;
			end
			OP_JALR: begin
				ctrl.isJump = 1'b1;
				ctrl.isJalr = 1'b1;
				ctrl.wbSrc = WB_PC4;
				ctrl.regWe = 1'b1;
				imm = immI;
				legal = (funct3 == 3'b000);
			end
			OP_BRANCH: begin
				ctrl.isBranch = 1'b1;
				ctrl.branchFunct = instr.b.funct3;
				imm = immB;
				// 010 and 011 are unused branch encodings
				legal = (funct3[2:1] != 2'b01);
			end
			OP_LOAD: begin
				ctrl.aluSrcB = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.wbSrc = WB_MEM;
				ctrl.regWe = 1'b1;
				imm = immI;
				case (funct3)
					3'b000: ctrl.memSize = MEM_BYTE;
					3'b010: ctrl.memSize = MEM_WORD;
					3'b100: ctrl.memSize = MEM_BYTEU;
					default: legal = 1'b0;
				endcase
			end
			OP_STORE: begin
				ctrl.aluSrcB = 1'b1;
				ctrl.memWrite = 1'b1;
				imm = immS;
				case (funct3)
					3'b000: ctrl.memSize = MEM_BYTE;
					3'b010: ctrl.memSize = MEM_WORD;
					default: legal = 1'b0;
				endcase
			end
			OP_OPIMM: begin
				ctrl.aluOp = aluFromFunct(funct3, funct7[5], 1'b0);
				ctrl.aluSrcB = 1'b1;
				ctrl.regWe = 1'b1;
				imm = immI;
				if (funct3 == 3'b001)
					legal = (funct7 == 7'b0000000);
				else if (funct3 == 3'b101)
					legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
			end
			OP_OP: begin
				ctrl.aluOp = aluFromFunct(funct3, funct7[5], 1'b1);
				ctrl.regWe = 1'b1;
				legal = (funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			OP_SYSTEM: begin
				// Only EBREAK is decoded and it acts as halt
				ctrl.halt = 1'b1;
				legal = (instr == 32'h0010_0073);
			end
			default: legal = 1'b0;
		endcase
	end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile import rvPkg::*; (
	input logic CLK,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] wbRd,
	input logic [XLEN-1:0] wbData,
	input logic wbWe,
	output logic [XLEN-1:0] rs1Data,
	output logic [XLEN-1:0] rs2Data
);

	// x0 has no storage
	logic [XLEN-1:0] regs [1:31];

	function automatic logic [XLEN-1:0] readPort(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		else if (wbWe && wbRd == addr)
			return wbData;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge CLK) begin
		if (wbWe && wbRd != 5'd0) begin
			regs[wbRd] <= wbData;
		end
	end

	// Write-through so a reader in the same cycle sees the new value
	always_comb begin
		rs1Data = readPort(rs1);
		rs2Data = readPort(rs2);
	end

endmodule

// ==== src/prIdEx.sv ====
`timescale 1ns/1ps

module prIdEx import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input idExBundle_t idIn,
	output idExBundle_t idOut
);

	// Whole decode bundle moves as one word
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			// Bubble with valid and all control bits low
			idOut <= '0;
		end else begin
			idOut <= idIn;
		end
	end

endmodule

// ==== src/execUnit.sv ====
`timescale 1ns/1ps

module execUnit import rvPkg::*; (
	input idExBundle_t idEx,
	output exMemBundle_t exOut,
	output logic redirect,
	output logic [XLEN-1:0] redirectPc
);

	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] aluResult;
	logic [XLEN-1:0] jalrSum;
	logic [4:0] shamt;
	logic taken;

	assign opA = idEx.ctrl.aluSrcA ? idEx.pc : idEx.rs1Data;
	assign opB = idEx.ctrl.aluSrcB ? idEx.imm : idEx.rs2Data;
	assign shamt = opB[4:0];

	always_comb begin
		case (idEx.ctrl.aluOp)
			ADD: aluResult = opA + opB;
			SUB: aluResult = opA - opB;
			SLL: aluResult = opA << shamt;
			SLT: aluResult = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			SLTU: aluResult = {{(XLEN-1){1'b0}}, opA < opB};
			XOR: aluResult = opA ^ opB;
			SRL: aluResult = opA >> shamt;
			SRA: aluResult = $signed(opA) >>> shamt;
			OR: aluResult = opA | opB;
			AND: aluResult = opA & opB;
			PASSB: aluResult = opB;
			default: aluResult = '0;
		endcase
	end

	// Branch compare always uses the register operands
	always_comb begin
		case (idEx.ctrl.branchFunct)
			3'b000: taken = (idEx.rs1Data == idEx.rs2Data);
			3'b001: taken = (idEx.rs1Data != idEx.rs2Data);
			3'b100: taken = ($signed(idEx.rs1Data) < $signed(idEx.rs2Data));
			3'b101: taken = ($signed(idEx.rs1Data) >= $signed(idEx.rs2Data));
			3'b110: taken = (idEx.rs1Data < idEx.rs2Data);
			3'b111: taken = (idEx.rs1Data >= idEx.rs2Data);
			default: taken = 1'b0;
		endcase
	end

	assign jalrSum = idEx.rs1Data + idEx.imm;
	assign redirect = idEx.valid && (idEx.ctrl.isJump || (idEx.ctrl.isBranch && taken));
	assign redirectPc = idEx.ctrl.isJalr ? {jalrSum[XLEN-1:1], 1'b0} : idEx.pc + idEx.imm;

	always_comb begin
		exOut.valid = idEx.valid;
		exOut.aluResult = aluResult;
		exOut.storeData = idEx.rs2Data;
		exOut.pcPlus4 = idEx.pc + 32'd4;
		exOut.rd = idEx.rd;
		exOut.ctrl = idEx.ctrl;
	end

endmodule

// ==== src/memWbStage.sv ====
`timescale 1ns/1ps

module memWbStage import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input exMemBundle_t exIn,
	input logic redirectIn,
	input logic [XLEN-1:0] redirectPcIn,
	output memWbBundle_t wb,
	output logic redirectValid,
	output logic [XLEN-1:0] redirectPc
);

	exMemBundle_t exMem;
	memWbBundle_t wbNext;
	logic [XLEN-1:0] dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0] wordAddr;
	logic [1:0] byteSel;
	logic [3:0] byteEn;
	logic [XLEN-1:0] wrData;
	logic [XLEN-1:0] rdWord;
	logic [7:0] rdByte;
	logic [XLEN-1:0] loadData;

	// EX/MEM register with the redirect riding along
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			exMem <= '0;
			redirectValid <= 1'b0;
			redirectPc <= '0;
		end else begin
			exMem <= exIn;
			redirectValid <= redirectIn;
			redirectPc <= redirectPcIn;
		end
	end

	assign wordAddr = exMem.aluResult[DMEM_AW+1:2];
	assign byteSel = exMem.aluResult[1:0];
	assign byteEn = (exMem.ctrl.memSize == MEM_WORD) ? 4'b1111 : (4'b0001 << byteSel);
	assign wrData = (exMem.ctrl.memSize == MEM_WORD) ? exMem.storeData :
		{4{exMem.storeData[7:0]}};

	always_ff @(posedge CLK) begin
		if (exMem.valid && exMem.ctrl.memWrite) begin
			for (int b = 0; b < 4; b++) begin
				if (byteEn[b])
					dmem[wordAddr][8*b +: 8] <= wrData[8*b +: 8];
			end
		end
	end

	// Asynchronous read
	assign rdWord = exMem.ctrl.memRead ? dmem[wordAddr] : '0;
	assign rdByte = rdWord[8*byteSel +: 8];

	always_comb begin
		case (exMem.ctrl.memSize)
			MEM_BYTE: loadData = {{24{rdByte[7]}}, rdByte};
			MEM_BYTEU: loadData = {24'b0, rdByte};
			default: loadData = rdWord;
		endcase
	end

	always_comb begin
		wbNext.valid = exMem.valid;
		case (exMem.ctrl.wbSrc)
			WB_MEM: wbNext.wbData = loadData;
			WB_PC4: wbNext.wbData = exMem.pcPlus4;
			default: wbNext.wbData = exMem.aluResult;
		endcase
		wbNext.rd = exMem.rd;
		// x0 writes never reach the write port
		wbNext.regWe = exMem.valid && exMem.ctrl.regWe && (exMem.rd != 5'd0);
		wbNext.halt = exMem.valid && exMem.ctrl.halt;
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			wb <= '0;
		end else begin
			wb <= wbNext;
		end
	end

endmodule

// ==== src/coreSlice.sv ====
`timescale 1ns/1ps

module coreSlice import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic [XLEN-1:0] instr,
	input logic [XLEN-1:0] pc,
	input logic instrValid,
	output logic wbValid,
	output logic [4:0] wbRd,
	output logic [XLEN-1:0] wbData,
	output logic redirectValid,
	output logic [XLEN-1:0] redirectPc,
	output logic halted
);

	instrWord_u instrWord;
	ctrlBundle_t idCtrl;
	logic [XLEN-1:0] idImm;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic legal;
	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;
	idExBundle_t idIn;
	idExBundle_t idOut;
	exMemBundle_t exOut;
	logic exRedirect;
	logic [XLEN-1:0] exRedirectPc;
	memWbBundle_t wb;
	logic wbWe;
	logic haltSticky;

	assign instrWord = instr;

	instrDecoder i_decoder (
		.instr(instrWord),
		.ctrl(idCtrl),
		.imm(idImm),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.legal(legal)
	);

	regFile i_regFile (
		.CLK(CLK),
		.rs1(rs1),
		.rs2(rs2),
		.wbRd(wb.rd),
		.wbData(wb.wbData),
		.wbWe(wbWe),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	// Illegal opcodes enter the pipe as bubbles
	always_comb begin
		idIn.valid = instrValid && legal;
		idIn.pc = pc;
		idIn.imm = idImm;
		idIn.rs1Data = rs1Data;
		idIn.rs2Data = rs2Data;
		idIn.rd = rd;
		idIn.ctrl = idCtrl;
	end

	prIdEx i_prIdEx (
		.CLK(CLK),
		.RSTn(RSTn),
		.idIn(idIn),
		.idOut(idOut)
	);

	execUnit i_exec (
		.idEx(idOut),
		.exOut(exOut),
		.redirect(exRedirect),
		.redirectPc(exRedirectPc)
	);

	memWbStage i_memWb (
		.CLK(CLK),
		.RSTn(RSTn),
		.exIn(exOut),
		.redirectIn(exRedirect),
		.redirectPcIn(exRedirectPc),
		.wb(wb),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc)
	);

	assign wbWe = wb.valid && wb.regWe;
	assign wbValid = wbWe;
	assign wbRd = wb.rd;
	assign wbData = wb.wbData;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			haltSticky <= 1'b0;
		end else if (wb.valid && wb.halt) begin
			haltSticky <= 1'b1;
		end
	end

	// Visible in the same cycle as the EBREAK writeback slot
	assign halted = haltSticky || (wb.valid && wb.halt);

endmodule

// ==== bench/wbChecker.sv ====
`timescale 1ns/1ps

module wbChecker import rvPkg::*; (
	input logic CLK,
	input logic RSTn,
	input logic expLine,
	input logic expWb,
	input logic [4:0] expRd,
	input logic [XLEN-1:0] expData,
	input logic expRedir,
	input logic [XLEN-1:0] expRedirPc,
	input logic expHalt,
	input logic wbValid,
	input logic [4:0] wbRd,
	input logic [XLEN-1:0] wbData,
	input logic redirectValid,
	input logic [XLEN-1:0] redirectPc,
	input logic halted,
	output int errorCount,
	output int checkCount,
	output int pending
);

	typedef struct packed {
		logic line;
		logic wb;
		logic [4:0] rd;
		logic [XLEN-1:0] data;
		logic redir;
		logic [XLEN-1:0] redirPc;
		logic halt;
	} expect_t;

	expect_t redirQ[$];
	expect_t wbQ[$];
	logic inReset = 1'b0;
	int errors = 0;
	int checks = 0;
	int pushedLines = 0;
	int checkedLines = 0;

	assign errorCount = errors;
	assign checkCount = checks;
	assign pending = pushedLines - checkedLines;

	task automatic compare(input string name, input logic [XLEN-1:0] expVal,
			input logic [XLEN-1:0] actVal);
		checks++;
		if (actVal !== expVal) begin
			errors++;
			$display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, expVal, actVal);
		end
	endtask

	// Expectations enter on the sampling edge and outputs are checked mid-cycle
	always @(posedge CLK or negedge CLK) begin
		expect_t e;
		if (CLK) begin
			inReset = RSTn;
			if (RSTn) begin
				redirQ.delete();
				wbQ.delete();
				checkedLines = pushedLines;
			end else begin
				e.line = expLine;
				e.wb = expWb;
				e.rd = expRd;
				e.data = expData;
				e.redir = expRedir;
				e.redirPc = expRedirPc;
				e.halt = expHalt;
				redirQ.push_back(e);
				wbQ.push_back(e);
				if (expLine)
					pushedLines++;
			end
		end else if (inReset) begin
			compare("wbValid", '0, 32'(wbValid));
			compare("redirectValid", '0, 32'(redirectValid));
			compare("halted", '0, 32'(halted));
		end else begin
			// Redirect one edge after sampling
			if (redirQ.size() > 1) begin
				e = redirQ.pop_front();
				compare("redirectValid", 32'(e.redir), 32'(redirectValid));
				if (e.redir)
					compare("redirectPc", e.redirPc, redirectPc);
			end
			// Writeback and halt two edges after sampling
			if (wbQ.size() > 2) begin
				e = wbQ.pop_front();
				compare("wbValid", 32'(e.wb), 32'(wbValid));
				if (e.wb) begin
					compare("wbRd", 32'(e.rd), 32'(wbRd));
					compare("wbData", e.data, wbData);
				end
				compare("halted", 32'(e.halt), 32'(halted));
				if (e.line)
					checkedLines++;
			end
		end
	end

endmodule

// ==== bench/tbCoreSlice.sv ====
`timescale 1ns/1ps

module tbCoreSlice import rvPkg::*; ();

	localparam int COLS = 9;
	localparam int DRAIN_LIMIT = 16;

	logic CLK;
	logic RSTn;
	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] pc;
	logic instrValid;
	logic wbValid;
	logic [4:0] wbRd;
	logic [XLEN-1:0] wbData;
	logic redirectValid;
	logic [XLEN-1:0] redirectPc;
	logic halted;
	logic expLine;
	logic expWb;
	logic [4:0] expRd;
	logic [XLEN-1:0] expData;
	logic expRedir;
	logic [XLEN-1:0] expRedirPc;
	logic expHalt;
	int errorCount;
	int checkCount;
	int pending;
	// Nine words per line of the golden file
	logic [XLEN-1:0] golden [1024];
	int lineCount;

	coreSlice i_dut (
		.CLK(CLK),
		.RSTn(RSTn),
		.instr(instr),
		.pc(pc),
		.instrValid(instrValid),
		.wbValid(wbValid),
		.wbRd(wbRd),
		.wbData(wbData),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.halted(halted)
	);

	wbChecker i_check (
		.CLK(CLK),
		.RSTn(RSTn),
		.expLine(expLine),
		.expWb(expWb),
		.expRd(expRd),
		.expData(expData),
		.expRedir(expRedir),
		.expRedirPc(expRedirPc),
		.expHalt(expHalt),
		.wbValid(wbValid),
		.wbRd(wbRd),
		.wbData(wbData),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.halted(halted),
		.errorCount(errorCount),
		.checkCount(checkCount),
		.pending(pending)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	function automatic logic [XLEN-1:0] field(input int line, input int col);
		return golden[10'(line * COLS + col)];
	endfunction

	task automatic applyLine(input int line);
		instr = field(line, 0);
		pc = field(line, 1);
		instrValid = field(line, 2) != 0;
		expLine = 1'b1;
		expWb = field(line, 3) != 0;
		expRd = 5'(field(line, 4));
		expData = field(line, 5);
		expRedir = field(line, 6) != 0;
		expRedirPc = field(line, 7);
		expHalt = field(line, 8) != 0;
	endtask

	// Halt expectation is sticky and keeps its value
	task automatic applyIdle();
		instr = '0;
		pc = '0;
		instrValid = 1'b0;
		expLine = 1'b0;
		expWb = 1'b0;
		expRd = '0;
		expData = '0;
		expRedir = 1'b0;
		expRedirPc = '0;
	endtask

	task automatic loadGolden();
		for (int i = 0; i < 1024; i++)
			golden[10'(i)] = 32'hFFFF_0000 | 32'(i);
		$readmemh("bench/program_golden.txt", golden);
		lineCount = 0;
		// Fill pattern left in the valid column marks the end
		while (lineCount < 1024 / COLS && field(lineCount, 2) <= 32'd1)
			lineCount++;
	endtask

	task automatic waitDrain(output bit timedOut);
		int cycles;
		cycles = 0;
		timedOut = 1'b0;
		while (pending != 0 && !timedOut) begin
			@(posedge CLK);
			cycles++;
			if (cycles >= DRAIN_LIMIT)
				timedOut = 1'b1;
		end
	endtask

	task automatic endRun(input string reason);
		if (reason != "")
			$display("Run stopped: %s", reason);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (reason == "" && errorCount == 0 && checkCount > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	initial begin
		int fd;
		bit timedOut;
		RSTn = 1'b1;
		expHalt = 1'b0;
		applyIdle();
		fd = $fopen("bench/program_golden.txt", "r");
		if (fd == 0) begin
			endRun("could not open bench/program_golden.txt");
		end else begin
			$fclose(fd);
			loadGolden();
			repeat (8) @(negedge CLK);
			RSTn = 1'b0;
			for (int k = 0; k < lineCount; k++) begin
				@(negedge CLK);
				applyLine(k);
			end
			@(negedge CLK);
			applyIdle();
			waitDrain(timedOut);
			if (timedOut) begin
				endRun("writebacks still pending when the drain timed out");
			end else if (lineCount == 0) begin
				endRun("golden file holds no instruction lines");
			end else begin
				// Second reset must clear the sticky halt
				@(negedge CLK);
				RSTn = 1'b1;
				expHalt = 1'b0;
				repeat (8) @(negedge CLK);
				RSTn = 1'b0;
				repeat (4) @(negedge CLK);
				endRun("");
			end
		end
	end

endmodule

// ==== bench/program_golden.txt ====
// instr pc instrValid | expected: wbValid rd wbData redirectValid redirectPc halted
// all hex, one instruction per line, applied one per cycle
00500093 00000100 1 1 01 00000005 0 00000000 0
ffd00113 00000104 1 1 02 fffffffd 0 00000000 0
800001b7 00000108 1 1 03 80000000 0 00000000 0
10000293 0000010c 1 1 05 00000100 0 00000000 0
00001317 00000110 1 1 06 00001110 0 00000000 0
00100013 00000114 1 0 00 00000000 0 00000000 0
002083b3 00000118 1 1 07 00000002 0 00000000 0
40208433 0000011c 1 1 08 00000008 0 00000000 0
00409493 00000120 1 1 09 00000050 0 00000000 0
4041d513 00000124 1 1 0a f8000000 0 00000000 0
0011d5b3 00000128 1 1 0b 04000000 0 00000000 0
00112633 0000012c 1 1 0c 00000001 0 00000000 0
001136b3 00000130 1 1 0d 00000000 0 00000000 0
00f14713 00000134 1 1 0e fffffff2 0 00000000 0
005177b3 00000138 1 1 0f 00000100 0 00000000 0
00108463 0000013c 1 0 00 00000000 1 00000144 0
00109463 00000140 1 0 00 00000000 0 00000000 0
fe1148e3 00000144 1 0 00 00000000 1 00000134 0
00115663 00000148 1 0 00 00000000 0 00000000 0
00116663 0000014c 1 0 00 00000000 0 00000000 0
00117863 00000150 1 0 00 00000000 1 00000160 0
0200086f 00000154 1 1 10 00000158 1 00000174 0
003288e7 00000158 1 1 11 0000015c 1 00000102 0
0022a423 0000015c 1 0 00 00000000 0 00000000 0
00e286a3 00000160 1 0 00 00000000 0 00000000 0
00000000 00000164 0 0 00 00000000 0 00000000 0
0082a903 00000168 1 1 12 fffffffd 0 00000000 0
00d28983 0000016c 1 1 13 fffffff2 0 00000000 0
00d2ca03 00000170 1 1 14 000000f2 0 00000000 0
ffffffff 00000174 1 0 00 00000000 0 00000000 0
00100a93 00000178 0 0 00 00000000 0 00000000 0
00100073 0000017c 1 0 00 00000000 0 00000000 1
7ff00b13 00000180 1 1 16 000007ff 0 00000000 1
00838bb3 00000184 1 1 17 0000000a 0 00000000 1
01490c33 00000188 1 1 18 000000ef 0 00000000 1

// ==== sim.f ====
src/rvPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/prIdEx.sv
src/execUnit.sv
src/memWbStage.sv
src/coreSlice.sv
bench/wbChecker.sv
bench/tbCoreSlice.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run from the project root, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module tbCoreSlice -f sim.f -o simv &&
	./obj_dir/simv > sim.log 2>&1 ;
cat sim.log 2>/dev/null
test -f sim.log &&
	! grep -q "=== FAIL ===" sim.log &&
	grep -q "=== PASS ===" sim.log &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }
